//--- design/xc_settings.svh
// Cross-correlator build settings.
// Input count, lag depth, counter width, period step and frame marker.
`ifndef XC_SETTINGS_SVH
`define XC_SETTINGS_SVH

`default_nettype none

// Two photon inputs.
`define XC_NUM_INPUTS 2
// Taps per input, lags 0 to 3.
`define XC_LAG_DEPTH 4
// Width of each coincidence counter.
`define XC_COUNT_WIDTH 8
// Cycles per unit of the period nibble.
`define XC_PERIOD_STEP 8
// Top nibble of every frame header.
`define XC_FRAME_MARKER 4'hA

`default_nettype wire

`endif

//--- design/xc_cmd_pkg.sv
// Command side types of the cross-correlator.
// Opcodes, the decoded command byte and the capture configuration.
`include "xc_settings.svh"
`default_nettype none

package xc_cmd_pkg;

	localparam int XC_LAG_W = $clog2(`XC_LAG_DEPTH);

	// Opcode sits in the low nibble of the command byte.
	typedef enum logic [3:0] {
		CLEAR          = 4'd0,
		SET_LINE       = 4'd1,
		SET_DELAY      = 4'd4,
		SET_PERIOD     = 4'd8,
		ENABLE_CAPTURE = 4'd13
	} xc_opcode_e;

	typedef struct packed {
		logic [3:0] arg;
		xc_opcode_e opcode;
	} xc_cmd_t;

	// Window length is (period + 1) steps.
	typedef struct packed {
		logic [3:0] period;
		logic [`XC_NUM_INPUTS-1:0][XC_LAG_W-1:0] lag;
	} xc_config_t;

endpackage

`default_nettype wire

//--- design/xc_data_pkg.sv
// Data side types of the cross-correlator.
// Count type, the per-window count set and the frame header.
`include "xc_settings.svh"
`default_nettype none

package xc_data_pkg;

	typedef logic [`XC_COUNT_WIDTH-1:0] xc_count_t;

	// Sent in this order after the header.
	typedef struct packed {
		xc_count_t auto0;
		xc_count_t auto1;
		xc_count_t cross01;
	} xc_counts_t;

	// Marker first, then the window sequence number.
	typedef struct packed {
		logic [3:0] marker;
		logic [3:0] seq;
	} xc_header_t;

endpackage

`default_nettype wire

//--- design/xc_capture_ctrl.sv
// Capture controller.
// Decodes command strobes, holds the lag and period configuration
// and sequences capture through IDLE, ARMED and RUN.
`include "xc_settings.svh"
`default_nettype none
`timescale 1ns/1ns

module xc_capture_ctrl (
	input  logic RXIF,
	input  logic reset,
	input  logic cmd_valid,
	input  xc_cmd_pkg::xc_cmd_t cmd_byte,
	input  logic window_end,
	output xc_cmd_pkg::xc_config_t cfg,
	output logic window_run
);
	import xc_cmd_pkg::*;

	typedef enum logic [1:0] {IDLE, ARMED, RUN} state_e;

	state_e state;
	logic [$clog2(`XC_NUM_INPUTS)-1:0] sel_line;
	logic stop_pend;
	logic start_req;
	logic stop_req;

	assign start_req = cmd_valid && cmd_byte.opcode == ENABLE_CAPTURE && cmd_byte.arg[0];
	assign stop_req = cmd_valid && cmd_byte.opcode == ENABLE_CAPTURE && !cmd_byte.arg[0];
	assign window_run = (state == RUN);

	// Configuration, written through the selected line.
	always_ff @(posedge RXIF) begin
		if (reset) begin
			cfg <= '0;
			sel_line <= '0;
		end else if (cmd_valid) begin
			case (cmd_byte.opcode)
				CLEAR:      cfg.lag <= '0;
				SET_LINE:   sel_line <= cmd_byte.arg[0];
				SET_DELAY:  cfg.lag[sel_line] <= cmd_byte.arg[XC_LAG_W-1:0];
				SET_PERIOD: cfg.period <= cmd_byte.arg;
				default:    ;
			endcase
		end
	end

	always_ff @(posedge RXIF) begin
		if (reset) begin
			state <= IDLE;
			stop_pend <= 1'b0;
		end else begin
			case (state)
				IDLE:    if (start_req) state <= ARMED;
				ARMED:   state <= stop_req ? IDLE : RUN;
				RUN:     if (window_end && (stop_pend || stop_req)) state <= IDLE;
				default: state <= IDLE;
			endcase
			// A stop waits for the running window to close.
			if (start_req || state != RUN)
				stop_pend <= 1'b0;
			else if (stop_req)
				stop_pend <= 1'b1;
		end
	end

	period_stable_a: assert property (@(posedge RXIF) disable iff (reset)
		window_run |-> $stable(cfg.period))
		else $error("period changed while capture is running");

endmodule

`default_nettype wire

//--- design/xc_window_timer.sv
// Integration window timer.
// Loads the window length on each start and counts down,
// marking the first and the last cycle of every window.
`include "xc_settings.svh"
`default_nettype none
`timescale 1ns/1ns

module xc_window_timer (
	input  logic RXIF,
	input  logic reset,
	input  logic window_run,
	input  xc_cmd_pkg::xc_config_t cfg,
	output logic window_start,
	output logic window_end
);
	localparam int REM_W = $clog2(16 * `XC_PERIOD_STEP + 1);

	logic [REM_W-1:0] remain;
	logic [REM_W-1:0] len_m1;

	// Cycles left after the start cycle.
	assign len_m1 = REM_W'((int'(cfg.period) + 1) * `XC_PERIOD_STEP - 1);

	// Zero means no window open, so a start may follow at once.
	assign window_start = window_run && (remain == '0);
	assign window_end = (remain == REM_W'(1));

	always_ff @(posedge RXIF) begin
		if (reset)
			remain <= '0;
		else if (window_start)
			remain <= len_m1;
		else if (remain != '0)
			remain <= remain - 1'b1;
	end

endmodule

`default_nettype wire

//--- design/xc_delay_line.sv
// Input delay line.
// Registers each input line into a short shift register and picks
// the tap given by that line's lag.
`include "xc_settings.svh"
`default_nettype none
`timescale 1ns/1ns

module xc_delay_line (
	input  logic RXIF,
	input  logic reset,
	input  logic [`XC_NUM_INPUTS-1:0] lines,
	input  xc_cmd_pkg::xc_config_t cfg,
	output logic [`XC_NUM_INPUTS-1:0] taps
);
	// Stage 0 holds the newest sample.
	logic [`XC_NUM_INPUTS-1:0][`XC_LAG_DEPTH-1:0] stage;

	for (genvar i = 0; i < `XC_NUM_INPUTS; i++) begin : g_line
		always_ff @(posedge RXIF) begin
			if (reset)
				stage[i] <= '0;
			else
				stage[i] <= {stage[i][`XC_LAG_DEPTH-2:0], lines[i]};
		end

		assign taps[i] = stage[i][cfg.lag[i]];
	end

endmodule

`default_nettype wire

//--- design/xc_correlator_core.sv
// Coincidence counter core.
// Counts per-window high cycles of each delayed tap and of both
// taps together, in saturating counters restarted on window_start.
`include "xc_settings.svh"
`default_nettype none
`timescale 1ns/1ns

module xc_correlator_core (
	input  logic RXIF,
	input  logic reset,
	input  logic window_start,
	input  logic window_end,
	input  logic [`XC_NUM_INPUTS-1:0] taps,
	output xc_data_pkg::xc_counts_t counts
);
	import xc_data_pkg::*;

	logic counting;
	logic cross_hit;

	function automatic xc_count_t sat_inc(input xc_count_t c, input logic hit);
		if (hit && c != '1)
			return xc_count_t'(c + 1'b1);
		return c;
	endfunction

	assign cross_hit = taps[0] & taps[1];

	// High from the cycle after start through window_end.
	always_ff @(posedge RXIF) begin
		if (reset)
			counting <= 1'b0;
		else if (window_start)
			counting <= 1'b1;
		else if (window_end)
			counting <= 1'b0;
	end

	// Start cycle loads its own sample.
	always_ff @(posedge RXIF) begin
		if (window_start) begin
			counts.auto0 <= xc_count_t'(taps[0]);
			counts.auto1 <= xc_count_t'(taps[1]);
			counts.cross01 <= xc_count_t'(cross_hit);
		end else if (counting) begin
			counts.auto0 <= sat_inc(counts.auto0, taps[0]);
			counts.auto1 <= sat_inc(counts.auto1, taps[1]);
			counts.cross01 <= sat_inc(counts.cross01, cross_hit);
		end
	end

	property p_no_wrap(xc_count_t c);
		@(posedge RXIF) disable iff (reset)
		counting && !window_end |=> c >= $past(c);
	endproperty

	auto0_no_wrap_a: assert property (p_no_wrap(counts.auto0))
		else $error("auto0 count wrapped");
	auto1_no_wrap_a: assert property (p_no_wrap(counts.auto1))
		else $error("auto1 count wrapped");
	cross_no_wrap_a: assert property (p_no_wrap(counts.cross01))
		else $error("cross01 count wrapped");

endmodule

`default_nettype wire

//--- design/xc_frame_serializer.sv
// Frame serializer.
// After each window latches the header and the final counts and
// sends the 32-bit frame out one nibble per cycle, MSB first.
`include "xc_settings.svh"
`default_nettype none
`timescale 1ns/1ns

module xc_frame_serializer (
	input  logic RXIF,
	input  logic reset,
	input  logic window_end,
	input  xc_data_pkg::xc_counts_t counts,
	output logic frame_valid,
	output logic [3:0] frame_nibble,
	output logic frame_last
);
	import xc_data_pkg::*;

	localparam int FRAME_BITS = $bits(xc_header_t) + $bits(xc_counts_t);
	localparam int NIBBLES = FRAME_BITS / 4;
	localparam int IDX_W = $clog2(NIBBLES);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NIBBLES - 1);

	xc_header_t header;
	logic [FRAME_BITS-1:0] frame_word;
	logic [FRAME_BITS-5:0] shreg;
	logic [IDX_W-1:0] nib_idx;
	logic [3:0] seq_num;

	assign header.marker = `XC_FRAME_MARKER;
	assign header.seq = seq_num;
	assign frame_word = {header, counts};

	// First nibble is the marker, the rest come from the latch.
	assign frame_nibble = (nib_idx == '0) ? frame_word[FRAME_BITS-1 -: 4]
		: shreg[FRAME_BITS-5 -: 4];
	assign frame_last = frame_valid && (nib_idx == LAST_IDX);

	always_ff @(posedge RXIF) begin
		if (reset) begin
			frame_valid <= 1'b0;
			nib_idx <= '0;
			seq_num <= '0;
		end else if (window_end) begin
			frame_valid <= 1'b1;
			nib_idx <= '0;
			seq_num <= seq_num + 1'b1;
		end else if (frame_valid) begin
			nib_idx <= nib_idx + 1'b1;
			if (frame_last)
				frame_valid <= 1'b0;
		end
	end

	// Counts are final in the first frame cycle.
	always_ff @(posedge RXIF) begin
		if (frame_valid && nib_idx == '0)
			shreg <= frame_word[FRAME_BITS-5:0];
		else
			shreg <= {shreg[FRAME_BITS-9:0], 4'h0};
	end

	no_overrun_a: assert property (@(posedge RXIF) disable iff (reset)
		window_end |-> !frame_valid || frame_last)
		else $error("window ended while a frame was still being sent");

endmodule

`default_nettype wire

//--- design/xc_top.sv
// Two-input photon-pulse cross-correlator.
// Command decoding, window timing, input delay, coincidence
// counting and nibble-wide frame output.
`include "xc_settings.svh"
`default_nettype none
`timescale 1ns/1ns

module xc_top (
	input  logic RXIF,
	input  logic reset,
	input  logic cmd_valid,
	input  logic [7:0] cmd_byte,
	input  logic [`XC_NUM_INPUTS-1:0] lines,
	output logic frame_valid,
	output logic [3:0] frame_nibble,
	output logic frame_last
);
	import xc_cmd_pkg::*;
	import xc_data_pkg::*;

	xc_cmd_t cmd;
	xc_config_t cfg;
	xc_counts_t counts;
	logic window_run;
	logic window_start;
	logic window_end;
	logic [`XC_NUM_INPUTS-1:0] taps;

	assign cmd = xc_cmd_t'(cmd_byte);

	xc_capture_ctrl xc_capture_ctrl_inst (
		.RXIF(RXIF), .reset(reset), .cmd_valid(cmd_valid), .cmd_byte(cmd),
		.window_end(window_end), .cfg(cfg), .window_run(window_run)
	);

	xc_window_timer xc_window_timer_inst (
		.RXIF(RXIF), .reset(reset), .window_run(window_run), .cfg(cfg),
		.window_start(window_start), .window_end(window_end)
	);

	xc_delay_line xc_delay_line_inst (
		.RXIF(RXIF), .reset(reset), .lines(lines), .cfg(cfg), .taps(taps)
	);

	xc_correlator_core xc_correlator_core_inst (
		.RXIF(RXIF), .reset(reset), .window_start(window_start),
		.window_end(window_end), .taps(taps), .counts(counts)
	);

	xc_frame_serializer xc_frame_serializer_inst (
		.RXIF(RXIF), .reset(reset), .window_end(window_end), .counts(counts),
		.frame_valid(frame_valid), .frame_nibble(frame_nibble), .frame_last(frame_last)
	);

endmodule

`default_nettype wire

//--- tb/xc_tb.sv
// Testbench for the cross-correlator.
// Reads commands, line patterns and expected counts per test from
// the testdata file, runs capture and checks every frame.
`include "xc_settings.svh"
`default_nettype none
`timescale 1ns/1ns

module xc_tb;
	import xc_cmd_pkg::*;
	import xc_data_pkg::*;

	localparam int NUM_TESTS = 5;
	localparam int REC_WORDS = 7;
	localparam int FRAME_TIMEOUT = 300;
	localparam int QUIET_CYCLES = 300;
	localparam logic [7:0] NO_CMD = 8'hFF;
	localparam logic [7:0] START_BYTE = {4'h1, ENABLE_CAPTURE};
	localparam logic [7:0] STOP_BYTE = {4'h0, ENABLE_CAPTURE};

	logic RXIF;
	logic reset;
	logic cmd_valid;
	logic [7:0] cmd_byte;
	logic [`XC_NUM_INPUTS-1:0] lines;
	logic frame_valid;
	logic [3:0] frame_nibble;
	logic frame_last;
	logic [31:0] tdata [NUM_TESTS*REC_WORDS];
	logic [3:0] exp_seq;

	xc_top xc_top_inst (
		.RXIF(RXIF), .reset(reset), .cmd_valid(cmd_valid), .cmd_byte(cmd_byte),
		.lines(lines), .frame_valid(frame_valid), .frame_nibble(frame_nibble),
		.frame_last(frame_last)
	);

	initial begin
		RXIF = 1'b0;
		forever #2 RXIF = ~RXIF;
	end

	task automatic abort_run();
		$display("tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_header(input xc_header_t got, input xc_header_t exp);
		if (got !== exp) begin
			$display("ERR %0t frame header got %h expected %h", $time, got, exp);
			abort_run();
		end
	endtask

	task automatic check_counts(input xc_counts_t got, input xc_counts_t exp);
		if (got !== exp) begin
			$display("ERR %0t frame counts got %h/%h/%h expected %h/%h/%h", $time,
				got.auto0, got.auto1, got.cross01, exp.auto0, exp.auto1, exp.cross01);
			abort_run();
		end
	endtask

	task automatic send_cmd(input logic [7:0] b);
		int gap;
		@(posedge RXIF);
		#1;
		cmd_valid = 1'b1;
		cmd_byte = b;
		@(posedge RXIF);
		#1;
		cmd_valid = 1'b0;
		gap = int'($urandom % 4);
		repeat (gap) @(posedge RXIF);
	endtask

	// One sample per cycle, with the stop strobe at its index.
	task automatic drive_samples(input logic [31:0] pat0, input logic [31:0] pat1,
			input int count, input int stop_at);
		for (int i = 0; i < count; i++) begin
			@(posedge RXIF);
			#1;
			lines[0] = pat0[i % 32];
			lines[1] = pat1[i % 32];
			cmd_valid = (i == stop_at);
			cmd_byte = (i == stop_at) ? STOP_BYTE : 8'h00;
		end
		@(posedge RXIF);
		#1;
		lines = '0;
		cmd_valid = 1'b0;
	endtask

	task automatic collect_frame(output logic [31:0] bits);
		int waited;
		waited = 0;
		bits = '0;
		@(negedge RXIF);
		while (frame_valid !== 1'b1) begin
			waited++;
			if (waited > FRAME_TIMEOUT) begin
				$display("Timeout: no frame arrived within %0d cycles", FRAME_TIMEOUT);
				abort_run();
			end
			@(negedge RXIF);
		end
		for (int n = 0; n < 8; n++) begin
			if (n > 0) begin
				@(negedge RXIF);
				check_flag("frame_valid", frame_valid, 1'b1);
			end
			check_flag("frame_last", frame_last, n == 7);
			bits = {bits[27:0], frame_nibble};
		end
	endtask

	task automatic check_quiet();
		repeat (QUIET_CYCLES) begin
			@(negedge RXIF);
			if (frame_valid !== 1'b0) begin
				$display("An extra frame arrived after capture was stopped");
				abort_run();
			end
		end
	endtask

	task automatic run_test(input int t);
		int base;
		int frames;
		int count;
		logic [31:0] cmds;
		logic [31:0] got;
		xc_header_t exp_header;
		base = t * REC_WORDS;
		cmds = tdata[base];
		frames = int'(tdata[base+3][31:16]);
		count = int'(tdata[base+3][15:0]);
		$display("Test %0d: %0d frame(s), %0d samples", t + 1, frames, count);
		for (int k = 3; k >= 0; k--) begin
			if (cmds[k*8 +: 8] != NO_CMD)
				send_cmd(cmds[k*8 +: 8]);
		end
		// Samples start in the cycle after the enable strobe.
		@(posedge RXIF);
		#1;
		cmd_valid = 1'b1;
		cmd_byte = START_BYTE;
		fork
			drive_samples(tdata[base+1], tdata[base+2], count, int'(tdata[base+4]));
			for (int f = 0; f < frames; f++) begin
				collect_frame(got);
				exp_seq = exp_seq + 4'd1;
				exp_header = {`XC_FRAME_MARKER, exp_seq};
				check_header(xc_header_t'(got[31:24]), exp_header);
				check_counts(xc_counts_t'(got[23:0]), xc_counts_t'(tdata[base+5+f][23:0]));
			end
		join
		check_quiet();
	endtask

	initial begin
		void'($urandom(32'h14f6));
		cmd_valid = 1'b0;
		cmd_byte = 8'h00;
		lines = '0;
		reset = 1'b1;
		exp_seq = 4'd0;
		$readmemh("tb/xc_testdata.txt", tdata);
		if ($isunknown(tdata[0]) || tdata[0] == '0) begin
			$display("The testdata file could not be read");
			abort_run();
		end
		repeat (3) @(posedge RXIF);
		#1;
		reset = 1'b0;
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+design
design/xc_cmd_pkg.sv
design/xc_data_pkg.sv
design/xc_capture_ctrl.sv
design/xc_window_timer.sv
design/xc_delay_line.sv
design/xc_correlator_core.sv
design/xc_frame_serializer.sv
design/xc_top.sv
tb/xc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cross-correlator testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module xc_tb \
	-Mdir obj_dir -o xc_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/xc_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation ended with status $status"
fi
exit "$status"

//--- tb/xc_testdata.txt
// Per test: commands (four bytes, top byte sent first, FF unused), line 0 pattern,
// line 1 pattern (bit i mod 32 is sample i), {frames, samples}, stop index, counts per frame.
// Zero lags, period 0.
08FFFFFF 0000006D 0000005B 00010008 00000002 00050503 00000000
// Line 1 lag 2, line 0 is line 1 two cycles later.
112408FF 000000B4 0000002D 00010008 00000002 00040404 00000000
// Line 1 lag back to 0, period 3, two frames.
0438FFFF 00FF0F0F 0F0F00FF 00020030 00000028 00101008 00080804
// Period 15, all ones over the longest window.
F8FFFFFF FFFFFFFF FFFFFFFF 00010080 00000005 00808080 00000000
// Line 0 lag 3 then CLEAR, period 1, stop in the second window.
01340018 3C3CFFFF FFFF0FF0 00020020 00000014 00100808 00081008
